//--- logic/matrix_macros.svh
`ifndef MATRIX_MACROS_SVH
`define MATRIX_MACROS_SVH

`define MAT_DATA_W      32
`define MAT_ROWS        12   // Not a power of two
`define MAT_ROW_IDX_W   4

`define MAT_COLS        16
`define MAT_COL_IDX_W   4

`define MAT_BANKS       4
`define MAT_BANK_SEL_W  2    // Low column bits pick the bank

// Columns held by one bank
`define MAT_BANK_COLS   (`MAT_COLS / `MAT_BANKS)

`endif

//--- logic/matrix_pkg.sv
`include "matrix_macros.svh"

package matrix_pkg;

  typedef logic [`MAT_DATA_W-1:0]    data_word_t;
  typedef logic [`MAT_ROW_IDX_W-1:0] row_idx_t;
  typedef logic [`MAT_COL_IDX_W-1:0] col_idx_t;

  // Upper column bits, the column inside one bank
  typedef logic [`MAT_COL_IDX_W-`MAT_BANK_SEL_W-1:0] bank_col_t;

  // Lower column bits
  typedef logic [`MAT_BANK_SEL_W-1:0] bank_sel_t;

endpackage

//--- logic/xfer_pkg.sv
package xfer_pkg;
  import matrix_pkg::*;

  typedef struct packed {
    logic       write;
    row_idx_t   row;
    col_idx_t   col;
    data_word_t wdata;
  } mat_req_t;

  typedef struct packed {
    logic       en;
    logic       write;
    row_idx_t   row;
    bank_col_t  col;
    data_word_t wdata;
  } bank_cmd_t;

  typedef struct packed {
    logic       done;      // Write completed
    logic       rd_valid;
    data_word_t rdata;
  } bank_rsp_t;

  typedef struct packed {
    logic       write;
    logic       err;
    data_word_t rdata;     // Zero for writes and errors
  } mat_rsp_t;

  typedef enum logic {
    ST_SCRUB,
    ST_RUN
  } router_state_t;

endpackage

//--- logic/mem_bank_d2.sv
`timescale 1ns/10ps
`include "matrix_macros.svh"

module mem_bank_d2 #(
  parameter int BANK_ID = 0
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                advance,
  input  xfer_pkg::bank_cmd_t cmd,
  output xfer_pkg::bank_rsp_t brsp
);
  import matrix_pkg::*;

  data_word_t mem [`MAT_ROWS][`MAT_BANK_COLS];

  logic       live;        // Scrub sweep has passed this bank
  logic       done_q;
  logic       rd_valid_q;
  data_word_t rdata_q;
  logic       fire;
  logic       last_word;

  assign fire      = cmd.en && advance;
  assign last_word = (cmd.row == row_idx_t'(`MAT_ROWS - 1)) &&
                     (cmd.col == bank_col_t'(`MAT_BANK_COLS - 1));

  // Scrub writes end on the last word, none of them answer
  always_ff @(posedge clk) begin
    if (reset) begin
      live       <= 1'b0;
      done_q     <= 1'b0;
      rd_valid_q <= 1'b0;
    end else if (advance) begin
      done_q     <= cmd.en && cmd.write && live;
      rd_valid_q <= cmd.en && !cmd.write;
      if (fire && cmd.write && last_word)
        live <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (cmd.write)
        mem[cmd.row][cmd.col] <= cmd.wdata;
      else
        rdata_q <= mem[cmd.row][cmd.col];   // Registered read
    end
  end

  assign brsp.done     = done_q;
  assign brsp.rd_valid = rd_valid_q;
  assign brsp.rdata    = rdata_q;

  // Router must refuse out-of-range rows before they reach a bank
  a_row_in_range: assert property (@(posedge clk) disable iff (reset)
    cmd.en |-> cmd.row < row_idx_t'(`MAT_ROWS))
    else $error("bank %0d: enabled command with row %0d out of range",
                BANK_ID, cmd.row);

  a_one_rsp_kind: assert property (@(posedge clk) disable iff (reset)
    !(brsp.done && brsp.rd_valid))
    else $error("bank %0d: done and rd_valid set together", BANK_ID);

endmodule

//--- logic/bank_router.sv
`timescale 1ns/10ps
`include "matrix_macros.svh"

module bank_router (
  input  logic                clk,
  input  logic                reset,
  input  logic                advance,
  input  logic                req_valid,
  output logic                req_ready,
  input  xfer_pkg::mat_req_t  req,
  output xfer_pkg::bank_cmd_t cmd [`MAT_BANKS],
  output logic                err_issue
);
  import matrix_pkg::*;
  import xfer_pkg::*;

  router_state_t state;
  row_idx_t      scrub_row;
  bank_col_t     scrub_col;
  logic          scrub_col_wrap;
  logic          scrub_last;
  logic          accept;
  logic          in_range;
  bank_sel_t     sel;
  logic [`MAT_BANKS-1:0] sel_onehot;

  // Command register, one payload shared by all banks
  logic [`MAT_BANKS-1:0] en_q;
  logic                  write_q;
  row_idx_t              row_q;
  bank_col_t             col_q;
  data_word_t            wdata_q;

  assign req_ready = (state == ST_RUN) && advance;
  assign accept    = req_valid && req_ready;
  assign in_range  = req.row < row_idx_t'(`MAT_ROWS);
  assign sel       = req.col[`MAT_BANK_SEL_W-1:0];

  assign scrub_col_wrap = scrub_col == bank_col_t'(`MAT_BANK_COLS - 1);
  assign scrub_last     = scrub_col_wrap && (scrub_row == row_idx_t'(`MAT_ROWS - 1));

  always_comb begin
    sel_onehot      = '0;
    sel_onehot[sel] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_SCRUB;
      scrub_row <= '0;
      scrub_col <= '0;
      en_q      <= '0;
      err_issue <= 1'b0;
    end else if (advance) begin
      en_q      <= '0;
      err_issue <= 1'b0;
      if (state == ST_SCRUB) begin
        en_q <= '1;   // Every bank clears the same word
        if (scrub_col_wrap) begin
          scrub_col <= '0;
          scrub_row <= scrub_row + 1'b1;
        end else begin
          scrub_col <= scrub_col + 1'b1;
        end
        if (scrub_last)
          state <= ST_RUN;
      end else if (accept) begin
        err_issue <= !in_range;
        en_q      <= in_range ? sel_onehot : '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      if (state == ST_SCRUB) begin
        write_q <= 1'b1;
        row_q   <= scrub_row;
        col_q   <= scrub_col;
        wdata_q <= '0;
      end else if (accept) begin
        write_q <= req.write;
        row_q   <= req.row;
        col_q   <= req.col[`MAT_COL_IDX_W-1:`MAT_BANK_SEL_W];
        wdata_q <= req.wdata;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `MAT_BANKS; i++) begin
      cmd[i].en    = en_q[i];
      cmd[i].write = write_q;
      cmd[i].row   = row_q;
      cmd[i].col   = col_q;
      cmd[i].wdata = wdata_q;
    end
  end

  a_no_ready_in_scrub: assert property (@(posedge clk) disable iff (reset)
    state == ST_SCRUB |-> !req_ready)
    else $error("router: req_ready high while scrub is running");

endmodule

//--- logic/rsp_collector.sv
`timescale 1ns/10ps
`include "matrix_macros.svh"

module rsp_collector (
  input  logic                clk,
  input  logic                reset,
  input  xfer_pkg::bank_rsp_t brsp [`MAT_BANKS],
  input  logic                err_issue,
  output logic                advance,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output xfer_pkg::mat_rsp_t  rsp
);
  import xfer_pkg::*;

  logic                  err_q;     // Lines up with the bank stage
  logic                  any_src;
  mat_rsp_t              merged;
  logic [2*`MAT_BANKS:0] src_vec;

  // Whole pipeline moves when the output slot is free or draining
  assign advance = !rsp_valid || rsp_ready;

  always_comb begin
    merged                = '0;
    merged.err            = err_q;
    src_vec               = '0;
    src_vec[2*`MAT_BANKS] = err_q;
    for (int i = 0; i < `MAT_BANKS; i++) begin
      src_vec[2*i]   = brsp[i].done;
      src_vec[2*i+1] = brsp[i].rd_valid;
      if (brsp[i].done)
        merged.write = 1'b1;
      if (brsp[i].rd_valid)
        merged.rdata |= brsp[i].rdata;
    end
  end

  assign any_src = |src_vec;

  always_ff @(posedge clk) begin
    if (reset) begin
      err_q     <= 1'b0;
      rsp_valid <= 1'b0;
    end else if (advance) begin
      err_q     <= err_issue;
      rsp_valid <= any_src;
    end
  end

  always_ff @(posedge clk) begin
    if (advance)
      rsp <= merged;
  end

  // Only one item per pipeline slot across all banks and the error path
  a_one_source: assert property (@(posedge clk) disable iff (reset)
    $onehot0(src_vec))
    else $error("collector: more than one response source active %b", src_vec);

  a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("collector: response changed while stalled");

endmodule

//--- logic/banked_matrix_mem.sv
`timescale 1ns/10ps
`include "matrix_macros.svh"

module banked_matrix_mem (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_valid,
  output logic               req_ready,
  input  xfer_pkg::mat_req_t req,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output xfer_pkg::mat_rsp_t rsp
);
  import xfer_pkg::*;

  bank_cmd_t cmd [`MAT_BANKS];
  bank_rsp_t brsp [`MAT_BANKS];
  logic      advance;     // Global pipeline enable
  logic      err_issue;

  bank_router router_i (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .cmd       (cmd),
    .err_issue (err_issue)
  );

  for (genvar i = 0; i < `MAT_BANKS; i++) begin : g_bank
    mem_bank_d2 #(
      .BANK_ID (i)
    ) bank_i (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .cmd     (cmd[i]),
      .brsp    (brsp[i])
    );
  end

  rsp_collector collector_i (
    .clk       (clk),
    .reset     (reset),
    .brsp      (brsp),
    .err_issue (err_issue),
    .advance   (advance),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

endmodule

//--- testbench/tb_banked_matrix_mem.sv
`timescale 1ns/10ps
`include "matrix_macros.svh"

module tb_banked_matrix_mem;
  import matrix_pkg::*;
  import xfer_pkg::*;

  localparam int TIMEOUT = 300;   // Cycles per wait

  logic     clk;
  logic     reset;
  logic     req_valid;
  logic     req_ready;
  mat_req_t req;
  logic     rsp_valid;
  logic     rsp_ready;
  mat_rsp_t rsp;

  data_word_t ref_mem [`MAT_ROWS][`MAT_COLS];
  mat_rsp_t   exp_q [$];
  mat_rsp_t   exp_head;
  mat_rsp_t   rsp_hold;       // Response as seen before the edge
  logic       exp_avail;
  logic       rsp_taken;
  logic       rand_ready;
  logic       b2b;
  string      test_name;
  int         value_errs;
  int         proto_errs;
  int         timeouts;

  banked_matrix_mem dut_i (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Output back-pressure random or held high
  initial begin
    rsp_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      rsp_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  // Expected queue head refreshed between edges
  always @(negedge clk) begin
    if (reset) begin
      rsp_taken = 1'b0;
    end else begin
      if (rsp_taken && exp_q.size() > 0)
        exp_q.delete(0);
      rsp_taken = rsp_valid && rsp_ready;
    end
    exp_avail = exp_q.size() > 0;
    exp_head  = exp_avail ? exp_q[0] : '0;
    rsp_hold  = rsp;
  end

  a_rsp_match: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && rsp_ready |-> exp_avail && rsp == exp_head)
    else begin
      if (!exp_avail) begin
        proto_errs++;
        $display("Response in %s arrived with no request outstanding", test_name);
      end else begin
        value_errs++;
        $display("** Error %s: expected %h, actual %h", test_name, exp_head, rsp_hold);
      end
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
      proto_errs++;
      $display("Response in %s changed or vanished while rsp_ready was low", test_name);
    end

  // Transfer on edge e shows up after edge e+2
  a_b2b_latency: assert property (@(posedge clk) disable iff (reset)
    b2b && req_valid && req_ready |-> ##3 (rsp_valid && rsp_ready))
    else begin
      proto_errs++;
      $display("Response in %s did not appear two cycles after its request", test_name);
    end

  a_b2b_ready: assert property (@(posedge clk) disable iff (reset)
    b2b |-> req_ready)
    else begin
      proto_errs++;
      $display("req_ready dropped in %s with rsp_ready held high", test_name);
    end

  function automatic void push_expected(input mat_req_t r);
    mat_rsp_t e;
    e = '0;
    if (r.row >= row_idx_t'(`MAT_ROWS)) begin
      e.err = 1'b1;   // Refused so no bank is touched
    end else if (r.write) begin
      e.write = 1'b1;
      ref_mem[r.row][r.col] = r.wdata;
    end else begin
      e.rdata = ref_mem[r.row][r.col];
    end
    exp_q.push_back(e);
  endfunction

  task automatic finish_run();
    $display("Closing report: value errors %0d, protocol errors %0d, timeouts %0d",
             value_errs, proto_errs, timeouts);
    if (value_errs == 0 && proto_errs == 0 && timeouts == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    timeouts++;
    $display("Timeout in %s: %s", test_name, what);
    finish_run();
  endtask

  // Scrub after every reset leaves all words zero
  task automatic pulse_reset();
    reset = 1'b1;
    for (int r = 0; r < `MAT_ROWS; r++)
      for (int c = 0; c < `MAT_COLS; c++)
        ref_mem[r][c] = '0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // Called just after a rising edge
  task automatic send_req(input logic wr, input row_idx_t row, input col_idx_t col,
                          input data_word_t wdata);
    mat_req_t r;
    int       waited;
    r.write   = wr;
    r.row     = row;
    r.col     = col;
    r.wdata   = wdata;
    req       = r;
    req_valid = 1'b1;
    waited    = 0;
    @(negedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > TIMEOUT)
        abort_on_timeout("request was never accepted");
      @(negedge clk);
    end
    push_expected(r);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic read_all_words();
    for (int r = 0; r < `MAT_ROWS; r++)
      for (int c = 0; c < `MAT_COLS; c++)
        send_req(1'b0, row_idx_t'(r), col_idx_t'(c), '0);
  endtask

  task automatic wait_scrub_done();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > TIMEOUT)
        abort_on_timeout("req_ready never rose after reset");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT)
        abort_on_timeout("outstanding responses never arrived");
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    reset      = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    rand_ready = 1'b0;
    b2b        = 1'b0;
    value_errs = 0;
    proto_errs = 0;
    timeouts   = 0;
    test_name  = "reset";
    void'($urandom(32'h3c9a));
    pulse_reset();

    test_name = "scrub_zero";
    wait_scrub_done();
    read_all_words();
    wait_drain();

    test_name = "write_read_all";
    for (int r = 0; r < `MAT_ROWS; r++)
      for (int c = 0; c < `MAT_COLS; c++)
        send_req(1'b1, row_idx_t'(r), col_idx_t'(c), data_word_t'($urandom));
    read_all_words();
    wait_drain();

    test_name = "row_range";
    for (int r = `MAT_ROWS; r < 16; r++) begin
      send_req(1'b1, row_idx_t'(r), col_idx_t'(r), data_word_t'($urandom));
      send_req(1'b0, row_idx_t'(r), col_idx_t'(r), '0);
      send_req(1'b0, '0, col_idx_t'(r), '0);   // Row 0 must be untouched
    end
    wait_drain();

    // Memory now holds written data for the second scrub to clear
    test_name = "rescrub_zero";
    pulse_reset();
    wait_scrub_done();
    read_all_words();
    wait_drain();

    test_name = "random_stall";
    @(negedge clk);
    rand_ready = 1'b1;
    @(posedge clk);
    #1;
    repeat (80)
      send_req(1'($urandom_range(0, 1)), row_idx_t'($urandom_range(0, 15)),
               col_idx_t'($urandom_range(0, 15)), data_word_t'($urandom));
    wait_drain();
    @(negedge clk);
    rand_ready = 1'b0;
    @(posedge clk);
    #1;

    test_name = "back_to_back";
    @(negedge clk);
    b2b = 1'b1;
    @(posedge clk);
    #1;
    repeat (32)
      send_req(1'($urandom_range(0, 1)), row_idx_t'($urandom_range(0, `MAT_ROWS - 1)),
               col_idx_t'($urandom_range(0, 15)), data_word_t'($urandom));
    wait_drain();
    @(negedge clk);
    b2b = 1'b0;
    repeat (4) @(posedge clk);

    finish_run();
  end

endmodule

//--- tb.f
+incdir+logic
logic/matrix_pkg.sv
logic/xfer_pkg.sv
logic/mem_bank_d2.sv
logic/bank_router.sv
logic/rsp_collector.sv
logic/banked_matrix_mem.sv
testbench/tb_banked_matrix_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the banked matrix memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_sim

verilator --binary --timing --assert \
  --top-module tb_banked_matrix_mem \
  -Mdir obj_dir -o "$BIN" \
  -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
